// File: sim.f
source/byp_pkg.sv
source/hazard_detect.sv
source/stall_ctrl.sv
source/fwd_ctrl.sv
source/byp_unit.sv
+incdir+dv
dv/tb_byp_unit.sv

// File: Makefile
# Verilator build and run for the bypass unit testbench

TOP       ?= tb_byp_unit
SIM_F     ?= sim.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(SIM_F)

# The log decides the result, the simulator status alone is not trusted
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_byp_checks.svh
// Right-shifting Galois LFSR, one call per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// Collects n bits with one LFSR step each, the newest bit lands in bit 0
function automatic logic [31:0] rand_bits(input int unsigned n);
  logic [31:0] v;
  v = '0;
  for (int unsigned i = 0; i < n; i++) begin
    lfsr = lfsr_next(lfsr);
    v = {v[30:0], lfsr[0]};
  end
  return v;
endfunction

// Prints the reason, then ends the run at once
task automatic stop_run(input string msg);
  $display("%s", msg);
  $display("SIMULATION FAILED");
  $fatal(1);
endtask

task automatic check_fwd_sel(input string name, input byp_pkg::fwd_sel_e exp_v,
                             input byp_pkg::fwd_sel_e act_v);
  if (act_v !== exp_v) begin
    stop_run($sformatf("Error %s expected 0x%0h actual 0x%0h", name, exp_v, act_v));
  end
endtask

task automatic check_jalr_sel(input string name, input byp_pkg::jalr_sel_e exp_v,
                              input byp_pkg::jalr_sel_e act_v);
  if (act_v !== exp_v) begin
    stop_run($sformatf("Error %s expected 0x%0h actual 0x%0h", name, exp_v, act_v));
  end
endtask

task automatic check_stall(input string name, input logic exp_v, input logic act_v);
  if (act_v !== exp_v) begin
    stop_run($sformatf("Error %s expected 0x%0h actual 0x%0h", name, exp_v, act_v));
  end
endtask

// File: dv/tb_byp_unit.sv
module tb_byp_unit;
  timeunit 1ns;
  timeprecision 1ps;

  logic               clk;
  logic               rst_n;
  byp_pkg::id_stage_t id_s;
  byp_pkg::ex_stage_t ex_s;
  byp_pkg::wb_stage_t wb_s;
  logic               wb_ready;
  byp_pkg::byp_ctrl_t ctrl;
  // Shared random state that rand_bits steps
  logic [31:0]        lfsr;

  `include "tb_byp_checks.svh"

  byp_unit dut_i (
    .id_i       (id_s),
    .ex_i       (ex_s),
    .wb_i       (wb_s),
    .wb_ready_i (wb_ready),
    .ctrl_o     (ctrl)
  );

  always #5 clk = ~clk;

  // Reset gates the start of the test sequence
  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Drives one set of inputs after the rising edge and returns at the falling edge
  task automatic apply(input byp_pkg::id_stage_t id_v, input byp_pkg::ex_stage_t ex_v,
                       input byp_pkg::wb_stage_t wb_v, input logic ready_v);
    @(posedge clk);
    #1;
    id_s     = id_v;
    ex_s     = ex_v;
    wb_s     = wb_v;
    wb_ready = ready_v;
    @(negedge clk);
  endtask

  // Reference select for one read port
  function automatic byp_pkg::fwd_sel_e model_fwd(input logic re, input byp_pkg::reg_addr_t ra,
                                                  input byp_pkg::ex_stage_t ex_v,
                                                  input byp_pkg::wb_stage_t wb_v);
    if (!re || ra == 5'd0) begin
      return byp_pkg::FWD_REGFILE;
    end
    if (ex_v.instr_valid && ex_v.rf_we && ex_v.rf_waddr == ra) begin
      return byp_pkg::FWD_EX;
    end
    if (wb_v.instr_valid && wb_v.rf_we && wb_v.rf_waddr == ra) begin
      return byp_pkg::FWD_WB;
    end
    return byp_pkg::FWD_REGFILE;
  endfunction

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  // Every field is busy except the valid bits, which stay low
  task automatic test_idle();
    byp_pkg::id_stage_t id_v;
    byp_pkg::ex_stage_t ex_v;
    byp_pkg::wb_stage_t wb_v;
    id_v = '1;
    ex_v = '1;
    wb_v = '1;
    id_v.instr_valid = 1'b0;
    ex_v.instr_valid = 1'b0;
    wb_v.instr_valid = 1'b0;
    apply(id_v, ex_v, wb_v, 1'b0);
    check_fwd_sel("op_a_sel", byp_pkg::FWD_REGFILE, ctrl.op_a_sel);
    check_fwd_sel("op_b_sel", byp_pkg::FWD_REGFILE, ctrl.op_b_sel);
    check_jalr_sel("jalr_sel", byp_pkg::JALR_REGFILE, ctrl.jalr_sel);
    check_stall("load_stall", 1'b0, ctrl.load_stall);
    check_stall("jalr_stall", 1'b0, ctrl.jalr_stall);
    check_stall("csr_stall", 1'b0, ctrl.csr_stall);
    check_stall("wfi_stall", 1'b0, ctrl.wfi_stall);
    check_stall("deassert_we", 1'b0, ctrl.deassert_we);
  endtask

  // Addresses kept to x0..x3 so that matches happen often
  task automatic test_fwd_random();
    byp_pkg::id_stage_t id_v;
    byp_pkg::ex_stage_t ex_v;
    byp_pkg::wb_stage_t wb_v;
    logic [31:0]        r;
    for (int n = 0; n < 200; n++) begin
      id_v = '0;
      ex_v = '0;
      wb_v = '0;
      r = rand_bits(15);
      id_v.instr_valid = r[0];
      id_v.rf_re       = r[2:1];
      id_v.rf_raddr[0] = {3'b000, r[4:3]};
      id_v.rf_raddr[1] = {3'b000, r[6:5]};
      ex_v.instr_valid = r[7];
      ex_v.rf_we       = r[8];
      ex_v.rf_waddr    = {3'b000, r[10:9]};
      wb_v.instr_valid = r[11];
      wb_v.rf_we       = r[12];
      wb_v.rf_waddr    = {3'b000, r[14:13]};
      apply(id_v, ex_v, wb_v, 1'b1);
      check_fwd_sel("op_a_sel", model_fwd(id_v.rf_re[0], id_v.rf_raddr[0], ex_v, wb_v),
                    ctrl.op_a_sel);
      check_fwd_sel("op_b_sel", model_fwd(id_v.rf_re[1], id_v.rf_raddr[1], ex_v, wb_v),
                    ctrl.op_b_sel);
    end
  endtask

  task automatic test_load_use();
    byp_pkg::id_stage_t id_v;
    byp_pkg::ex_stage_t ex_v;
    byp_pkg::wb_stage_t wb_v;
    id_v = '0;
    ex_v = '0;
    wb_v = '0;
    id_v.instr_valid = 1'b1;
    id_v.rf_re       = 2'b01;
    id_v.rf_raddr[0] = 5'd7;
    ex_v.instr_valid = 1'b1;
    ex_v.rf_we       = 1'b1;
    ex_v.rf_waddr    = 5'd7;
    ex_v.lsu_en      = 1'b1;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("load_stall", 1'b1, ctrl.load_stall);
    // Same producer as an ALU op is simply forwarded
    ex_v.lsu_en = 1'b0;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("load_stall", 1'b0, ctrl.load_stall);
    check_fwd_sel("op_a_sel", byp_pkg::FWD_EX, ctrl.op_a_sel);
    // WB writer read on port B waits only while its data is pending
    ex_v = '0;
    id_v.rf_re       = 2'b10;
    id_v.rf_raddr[1] = 5'd7;
    wb_v.instr_valid = 1'b1;
    wb_v.rf_we       = 1'b1;
    wb_v.rf_waddr    = 5'd7;
    apply(id_v, ex_v, wb_v, 1'b0);
    check_stall("load_stall", 1'b1, ctrl.load_stall);
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("load_stall", 1'b0, ctrl.load_stall);
  endtask

  task automatic test_jalr();
    byp_pkg::id_stage_t id_v;
    byp_pkg::ex_stage_t ex_v;
    byp_pkg::wb_stage_t wb_v;
    id_v = '0;
    ex_v = '0;
    wb_v = '0;
    id_v.instr_valid = 1'b1;
    id_v.jalr        = 1'b1;
    id_v.rf_re       = 2'b01;
    id_v.rf_raddr[0] = 5'd9;
    ex_v.instr_valid = 1'b1;
    ex_v.rf_we       = 1'b1;
    ex_v.rf_waddr    = 5'd9;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("jalr_stall", 1'b1, ctrl.jalr_stall);
    // Without a jump in ID the same match is only forwarded
    id_v.jalr = 1'b0;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("jalr_stall", 1'b0, ctrl.jalr_stall);
    id_v.jalr = 1'b1;
    // Load result in WB cannot reach the target path
    ex_v = '0;
    wb_v.instr_valid = 1'b1;
    wb_v.rf_we       = 1'b1;
    wb_v.rf_waddr    = 5'd9;
    wb_v.lsu_en      = 1'b1;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("jalr_stall", 1'b1, ctrl.jalr_stall);
    wb_v.lsu_en = 1'b0;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("jalr_stall", 1'b0, ctrl.jalr_stall);
    check_jalr_sel("jalr_sel", byp_pkg::JALR_WB, ctrl.jalr_sel);
    // x0 as base never waits and never forwards
    id_v.rf_raddr[0] = 5'd0;
    ex_v             = '1;
    ex_v.rf_waddr    = 5'd0;
    wb_v.rf_waddr    = 5'd0;
    wb_v.lsu_en      = 1'b1;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("jalr_stall", 1'b0, ctrl.jalr_stall);
    check_jalr_sel("jalr_sel", byp_pkg::JALR_REGFILE, ctrl.jalr_sel);
  endtask

  task automatic test_csr_wfi_we();
    byp_pkg::id_stage_t id_v;
    byp_pkg::ex_stage_t ex_v;
    byp_pkg::wb_stage_t wb_v;
    // Reader kind k is a CSR access, mret or wfi
    // Writer slot s is a csr_en or mret in EX, then the same two in WB
    for (int k = 0; k < 3; k++) begin
      for (int s = 0; s < 4; s++) begin
        id_v = '0;
        ex_v = '0;
        wb_v = '0;
        id_v.instr_valid = 1'b1;
        id_v.csr_en      = (k == 0);
        id_v.mret        = (k == 1);
        id_v.wfi         = (k == 2);
        ex_v.instr_valid = (s < 2);
        ex_v.csr_en      = (s == 0);
        ex_v.mret        = (s == 1);
        wb_v.instr_valid = (s >= 2);
        wb_v.csr_en      = (s == 2);
        wb_v.mret        = (s == 3);
        apply(id_v, ex_v, wb_v, 1'b1);
        check_stall("csr_stall", 1'b1, ctrl.csr_stall);
      end
    end
    // Invalid writers hold nothing back
    ex_v = '0;
    wb_v = '0;
    ex_v.csr_en = 1'b1;
    wb_v.mret   = 1'b1;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("csr_stall", 1'b0, ctrl.csr_stall);
    // A plain instruction in ID does not wait on a CSR write
    id_v = '0;
    id_v.instr_valid = 1'b1;
    ex_v.instr_valid = 1'b1;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("csr_stall", 1'b0, ctrl.csr_stall);
    id_v = '0;
    ex_v = '0;
    ex_v.wfi = 1'b1;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("wfi_stall", 1'b0, ctrl.wfi_stall);
    ex_v.instr_valid = 1'b1;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("wfi_stall", 1'b1, ctrl.wfi_stall);
    ex_v = '0;
    id_v.fetch_err = 1'b1;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("deassert_we", 1'b0, ctrl.deassert_we);
    id_v.instr_valid = 1'b1;
    apply(id_v, ex_v, wb_v, 1'b1);
    check_stall("deassert_we", 1'b1, ctrl.deassert_we);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int unsigned cycles;
    id_s     = '0;
    ex_s     = '0;
    wb_s     = '0;
    wb_ready = 1'b1;
    lfsr     = 32'ha2bf296a;
    cycles   = 0;
    while (rst_n !== 1'b1) begin
      if (cycles == 20) begin
        stop_run("Reset was not released within 20 clock cycles");
      end
      @(posedge clk);
      cycles++;
    end
    test_idle();
    test_fwd_random();
    test_load_use();
    test_jalr();
    test_csr_wfi_we();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: source/byp_unit.sv
module byp_unit (
  input  byp_pkg::id_stage_t id_i,
  input  byp_pkg::ex_stage_t ex_i,
  input  byp_pkg::wb_stage_t wb_i,
  // Low while WB waits for load data
  input  logic               wb_ready_i,
  output byp_pkg::byp_ctrl_t ctrl_o
);

  // Matches shared by the stall and forward blocks
  byp_pkg::hazard_t haz;

  // Stall side
  logic load_stall;
  logic jalr_stall;
  logic csr_stall;
  logic wfi_stall;
  logic deassert_we;

  // Forward side
  byp_pkg::fwd_sel_e  op_a_sel;
  byp_pkg::fwd_sel_e  op_b_sel;
  byp_pkg::jalr_sel_e jalr_sel;

  ////////////////////////////////////////
  // Submodules
  ////////////////////////////////////////

  hazard_detect hazard_detect_i (
    .id_i  (id_i),
    .ex_i  (ex_i),
    .wb_i  (wb_i),
    .haz_o (haz)
  );

  stall_ctrl stall_ctrl_i (
    .id_i          (id_i),
    .ex_i          (ex_i),
    .wb_i          (wb_i),
    .wb_ready_i    (wb_ready_i),
    .haz_i         (haz),
    .load_stall_o  (load_stall),
    .jalr_stall_o  (jalr_stall),
    .csr_stall_o   (csr_stall),
    .wfi_stall_o   (wfi_stall),
    .deassert_we_o (deassert_we)
  );

  fwd_ctrl fwd_ctrl_i (
    .haz_i      (haz),
    .op_a_sel_o (op_a_sel),
    .op_b_sel_o (op_b_sel),
    .jalr_sel_o (jalr_sel)
  );

  // Pack both halves into the controller view
  assign ctrl_o = '{
    op_a_sel:    op_a_sel,
    op_b_sel:    op_b_sel,
    jalr_sel:    jalr_sel,
    load_stall:  load_stall,
    jalr_stall:  jalr_stall,
    csr_stall:   csr_stall,
    wfi_stall:   wfi_stall,
    deassert_we: deassert_we
  };

endmodule

// File: source/fwd_ctrl.sv
module fwd_ctrl (
  input  byp_pkg::hazard_t  haz_i,
  output byp_pkg::fwd_sel_e  op_a_sel_o,
  output byp_pkg::fwd_sel_e  op_b_sel_o,
  output byp_pkg::jalr_sel_e jalr_sel_o
);

  // Qualified matches per port
  logic [byp_pkg::NUM_READ_PORTS-1:0] ex_fwd;
  logic [byp_pkg::NUM_READ_PORTS-1:0] wb_fwd;

  assign ex_fwd = haz_i.ex_match & {byp_pkg::NUM_READ_PORTS{haz_i.ex_we}};
  assign wb_fwd = haz_i.wb_match & {byp_pkg::NUM_READ_PORTS{haz_i.wb_we}};

  ////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////

  // EX holds the younger value, so it overrides WB
  always_comb begin
    op_a_sel_o = byp_pkg::FWD_REGFILE;
    op_b_sel_o = byp_pkg::FWD_REGFILE;

    if (wb_fwd[byp_pkg::PORT_A]) begin
      op_a_sel_o = byp_pkg::FWD_WB;
    end
    if (wb_fwd[byp_pkg::PORT_B]) begin
      op_b_sel_o = byp_pkg::FWD_WB;
    end

    // A load in EX also matches here, but then ID is stalled anyway
    if (ex_fwd[byp_pkg::PORT_A]) begin
      op_a_sel_o = byp_pkg::FWD_EX;
    end
    if (ex_fwd[byp_pkg::PORT_B]) begin
      op_b_sel_o = byp_pkg::FWD_EX;
    end
  end

  ////////////////////////////////////////
  // Jump-register forwarding
  ////////////////////////////////////////

  // Select is a don't care when no jump is in ID or when it stalls
  always_comb begin
    jalr_sel_o = byp_pkg::JALR_REGFILE;
    if (haz_i.wb_we && haz_i.wb_jalr_match) begin
      jalr_sel_o = byp_pkg::JALR_WB;
    end
  end

endmodule

// File: source/stall_ctrl.sv
module stall_ctrl (
  input  byp_pkg::id_stage_t id_i,
  input  byp_pkg::ex_stage_t ex_i,
  input  byp_pkg::wb_stage_t wb_i,
  // Low while WB is still waiting for load data
  input  logic               wb_ready_i,
  input  byp_pkg::hazard_t   haz_i,
  output logic               load_stall_o,
  output logic               jalr_stall_o,
  output logic               csr_stall_o,
  output logic               wfi_stall_o,
  output logic               deassert_we_o
);

  // Loads in EX and WB
  logic ex_load;
  logic wb_load;

  // Instruction classes in ID that need a settled CSR state
  logic jalr_id;
  logic csr_read_id;

  // Some CSR gets written by EX or WB, mret counts as an implicit write
  logic csr_write_ex;
  logic csr_write_wb;
  logic csr_write_ex_wb;

  // A register of ID is produced by EX or WB
  logic ex_rd_hazard;
  logic wb_rd_hazard;

  ////////////////////////////////////////
  // Stage qualifiers
  ////////////////////////////////////////

  assign ex_load = ex_i.instr_valid && ex_i.lsu_en;
  assign wb_load = wb_i.instr_valid && wb_i.lsu_en;

  assign jalr_id = id_i.instr_valid && id_i.jalr;

  // WFI reads the privilege state, so it waits on CSR writes as well
  assign csr_read_id = id_i.instr_valid && (id_i.csr_en || id_i.mret || id_i.wfi);

  assign csr_write_ex    = ex_i.instr_valid && (ex_i.csr_en || ex_i.mret);
  assign csr_write_wb    = wb_i.instr_valid && (wb_i.csr_en || wb_i.mret);
  assign csr_write_ex_wb = csr_write_ex || csr_write_wb;

  // Any matched read port against a qualified writer
  assign ex_rd_hazard = haz_i.ex_we && (|haz_i.ex_match);
  assign wb_rd_hazard = haz_i.wb_we && (|haz_i.wb_match);

  ////////////////////////////////////////
  // Stall generation
  ////////////////////////////////////////

  always_comb begin
    load_stall_o = 1'b0;
    jalr_stall_o = 1'b0;
    csr_stall_o  = 1'b0;

    // Load data is not ready yet in EX, and in WB only once the bus answers
    if ((ex_load && ex_rd_hazard) || (!wb_ready_i && wb_rd_hazard)) begin
      load_stall_o = 1'b1;
    end

    // The target path only takes ALU results from WB
    // EX results and WB load data are too late for it
    if (jalr_id) begin
      if (haz_i.ex_we && haz_i.ex_jalr_match) begin
        jalr_stall_o = 1'b1;
      end
      if (haz_i.wb_we && haz_i.wb_jalr_match && wb_load) begin
        jalr_stall_o = 1'b1;
      end
    end

    // Hold the CSR reader until older CSR writes have retired
    if (csr_read_id && csr_write_ex_wb) begin
      csr_stall_o = 1'b1;
    end
  end

  // Nothing behind a WFI may move into EX while it is there
  assign wfi_stall_o = ex_i.instr_valid && ex_i.wfi;

  // A faulted fetch turns into a bubble that still carries its exception
  assign deassert_we_o = id_i.instr_valid && id_i.fetch_err;

endmodule

// File: source/hazard_detect.sv
module hazard_detect (
  input  byp_pkg::id_stage_t id_i,
  input  byp_pkg::ex_stage_t ex_i,
  input  byp_pkg::wb_stage_t wb_i,
  output byp_pkg::hazard_t   haz_o
);

  // Qualified register writers in EX and WB
  logic ex_we;
  logic wb_we;

  // Per-port compare results, before any write enable is applied
  logic [byp_pkg::NUM_READ_PORTS-1:0] ex_match;
  logic [byp_pkg::NUM_READ_PORTS-1:0] wb_match;

  // rs1 compare used by the jump-register path
  logic ex_jalr_match;
  logic wb_jalr_match;

  // A write only counts when the stage holds a real instruction
  assign ex_we = ex_i.rf_we && ex_i.instr_valid;
  assign wb_we = wb_i.rf_we && wb_i.instr_valid;

  ////////////////////////////////////////
  // Read port matches
  ////////////////////////////////////////

  // Reads of the zero register and disabled ports never see a hazard
  always_comb begin
    for (int unsigned i = 0; i < byp_pkg::NUM_READ_PORTS; i++) begin
      ex_match[i] = id_i.rf_re[i] && (id_i.rf_raddr[i] != byp_pkg::REG_ZERO) &&
                    (id_i.rf_raddr[i] == ex_i.rf_waddr);
      wb_match[i] = id_i.rf_re[i] && (id_i.rf_raddr[i] != byp_pkg::REG_ZERO) &&
                    (id_i.rf_raddr[i] == wb_i.rf_waddr);
    end
  end

  // A jump-register always reads rs1, so the read enable is implied
  assign ex_jalr_match = (id_i.rf_raddr[byp_pkg::PORT_A] != byp_pkg::REG_ZERO) &&
                         (id_i.rf_raddr[byp_pkg::PORT_A] == ex_i.rf_waddr);
  assign wb_jalr_match = (id_i.rf_raddr[byp_pkg::PORT_A] != byp_pkg::REG_ZERO) &&
                         (id_i.rf_raddr[byp_pkg::PORT_A] == wb_i.rf_waddr);

  // Consumers combine the matches with ex_we and wb_we themselves
  assign haz_o = '{
    ex_we:         ex_we,
    wb_we:         wb_we,
    ex_match:      ex_match,
    wb_match:      wb_match,
    ex_jalr_match: ex_jalr_match,
    wb_jalr_match: wb_jalr_match
  };

endmodule

// File: source/byp_pkg.sv
package byp_pkg;

  ////////////////////////////////////////
  // Register file geometry
  ////////////////////////////////////////

  // Number of register file read ports seen by the ID stage
  localparam int unsigned NUM_READ_PORTS = 2;

  // Register index width for a 32 entry register file
  localparam int unsigned REG_ADDR_W = 5;

  // Register index as decoded from the instruction
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Index zero always reads as zero and is never a real producer
  localparam reg_addr_t REG_ZERO = '0;

  // Port 0 carries rs1, which is also the jump-register base
  localparam int unsigned PORT_A = 0;
  localparam int unsigned PORT_B = 1;

  ////////////////////////////////////////
  // Pipeline stage views
  ////////////////////////////////////////

  // Instruction sitting in ID, straight from the decoder
  typedef struct packed {
    logic                                 instr_valid;
    // Instruction fetch returned a bus error
    logic                                 fetch_err;
    logic      [NUM_READ_PORTS-1:0]       rf_re;
    reg_addr_t [NUM_READ_PORTS-1:0]       rf_raddr;
    logic                                 jalr;
    logic                                 csr_en;
    logic                                 mret;
    logic                                 wfi;
  } id_stage_t;

  // ID/EX pipeline register
  typedef struct packed {
    logic      instr_valid;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      lsu_en;
    logic      csr_en;
    logic      mret;
    logic      wfi;
  } ex_stage_t;

  // EX/WB pipeline register, a WFI never lingers here so it has no flag
  typedef struct packed {
    logic      instr_valid;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      lsu_en;
    logic      csr_en;
    logic      mret;
  } wb_stage_t;

  ////////////////////////////////////////
  // Bypass selects and results
  ////////////////////////////////////////

  // Operand mux select in ID
  typedef enum logic [1:0] {
    FWD_REGFILE = 2'b00,
    FWD_EX      = 2'b01,
    FWD_WB      = 2'b10
  } fwd_sel_e;

  // Jump-register target mux select, only WB can feed the target path
  typedef enum logic {
    JALR_REGFILE = 1'b0,
    JALR_WB      = 1'b1
  } jalr_sel_e;

  // Address compare results shared by the stall and forward logic
  typedef struct packed {
    logic                      ex_we;
    logic                      wb_we;
    logic [NUM_READ_PORTS-1:0] ex_match;
    logic [NUM_READ_PORTS-1:0] wb_match;
    logic                      ex_jalr_match;
    logic                      wb_jalr_match;
  } hazard_t;

  // Everything the pipeline controller needs from the bypass unit
  typedef struct packed {
    fwd_sel_e  op_a_sel;
    fwd_sel_e  op_b_sel;
    jalr_sel_e jalr_sel;
    logic      load_stall;
    logic      jalr_stall;
    logic      csr_stall;
    logic      wfi_stall;
    logic      deassert_we;
  } byp_ctrl_t;

endpackage
